/* filelist.f */
key_pkg.sv
game_pkg.sv
key_state_tracker.sv
letter_checker.sv
penalty_timer.sv
game_fsm.sv
typing_game_top.sv
typing_game_checker.sv
typing_game_monitor.sv
tb_typing_game.sv

/* game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  key_pkg::key_map_t      key_down,
    input  key_pkg::key_code_t     last_change,
    input  logic                   been_ready,
    input  logic                   wrong,
    input  game_pkg::word_cnt_t    word_cnt,
    input  game_pkg::penalty_cnt_t wrong_cnt,
    output game_pkg::game_state_t  state,
    output game_pkg::start_cnt_t   stcnt
);

    game_pkg::game_state_t next_state;
    game_pkg::start_cnt_t  next_stcnt;
    logic                  enter_press;
    logic                  enter_held;
    logic                  start_done;

    // WAIT needs a fresh press, so an Enter still held from FINISH
    // cannot restart the game by itself.
    assign enter_held  = key_down[last_change] && (last_change == key_pkg::KEY_ENTER);
    assign enter_press = been_ready && enter_held;
    assign start_done  = (stcnt == game_pkg::START_DELAY - 1'b1);

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            game_pkg::WAIT: begin
                if (enter_press) begin
                    next_state = game_pkg::WAIT_TO_START;
                end
            end
            game_pkg::WAIT_TO_START: begin
                if (start_done) begin
                    next_state = game_pkg::WORD;
                end
            end
            game_pkg::WORD: begin
                if (word_cnt == game_pkg::WORD_TARGET) begin
                    next_state = game_pkg::FINISH;
                end else if (wrong) begin
                    next_state = game_pkg::WRONG;
                end
            end
            game_pkg::WRONG: begin
                if (wrong_cnt == '0) begin
                    next_state = game_pkg::WORD;  // Penalty served.
                end
            end
            game_pkg::FINISH: begin
                if (enter_held) begin
                    next_state = game_pkg::WAIT;
                end
            end
            default: begin
                next_state = game_pkg::WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= game_pkg::WAIT;
        end else begin
            state <= next_state;
        end
    end

    // ==================================================
    // Start delay counter
    // ==================================================
    // Runs only in WAIT_TO_START.
    assign next_stcnt = (state != game_pkg::WAIT_TO_START) ? '0 : stcnt + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            stcnt <= '0;
        end else begin
            stcnt <= next_stcnt;
        end
    end

endmodule

/* game_pkg.sv */
package game_pkg;

    // ==================================================
    // Game phases
    // ==================================================
    typedef enum logic [2:0] {
        WAIT          = 3'd0,
        WAIT_TO_START = 3'd1,
        WORD          = 3'd2,
        WRONG         = 3'd3,
        FINISH        = 3'd4
    } game_state_t;

    // ==================================================
    // Counter widths and types
    // ==================================================
    localparam int WORD_CNT_W    = 11;
    localparam int MISTAKE_CNT_W = 8;
    localparam int PENALTY_CNT_W = 6;
    localparam int START_CNT_W   = 29;

    typedef logic [WORD_CNT_W-1:0]    word_cnt_t;     // Correct letters typed.
    typedef logic [MISTAKE_CNT_W-1:0] mistake_cnt_t;  // Saturates at all ones.
    typedef logic [PENALTY_CNT_W-1:0] penalty_cnt_t;
    typedef logic [START_CNT_W-1:0]   start_cnt_t;

    // ==================================================
    // Game scale
    // ==================================================
    // Kept small for simulation, hardware would use seconds worth of cycles.
    localparam word_cnt_t    WORD_TARGET    = 11'd6;
    localparam start_cnt_t   START_DELAY    = 29'd8;
    localparam penalty_cnt_t PENALTY_CYCLES = 6'd5;

endpackage

/* key_pkg.sv */
package key_pkg;

    // ==================================================
    // Key code and held-key map widths
    // ==================================================
    localparam int KEY_CODE_W = 9;                // Bit 8 carries the E0 prefix.
    localparam int KEY_MAP_W  = 1 << KEY_CODE_W;  // One bit per possible code.

    typedef logic [KEY_CODE_W-1:0] key_code_t;
    typedef logic [KEY_MAP_W-1:0]  key_map_t;

    // ==================================================
    // Codes the game recognizes
    // ==================================================
    localparam key_code_t KEY_ENTER = 9'd90;

    // Home row letters used by the target sequence.
    localparam key_code_t KEY_A = 9'd28;
    localparam key_code_t KEY_S = 9'd27;
    localparam key_code_t KEY_D = 9'd35;
    localparam key_code_t KEY_F = 9'd43;
    localparam key_code_t KEY_J = 9'd59;
    localparam key_code_t KEY_K = 9'd66;

endpackage

/* key_state_tracker.sv */
`timescale 1ns/1ps

module key_state_tracker (
    input  logic               clk,
    input  logic               rst,
    input  logic               key_valid,
    input  key_pkg::key_code_t key_code,
    input  logic               key_release,
    output key_pkg::key_map_t  key_down,
    output key_pkg::key_code_t last_change,
    output logic               been_ready
);

    logic held_now;
    logic fresh_press;

    // A make of a key that is already down is a typematic repeat.
    assign held_now    = key_down[key_code];
    assign fresh_press = key_valid && !key_release && !held_now;

    // ==================================================
    // Held-key map
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            key_down <= '0;
        end else if (key_valid) begin
            key_down[key_code] <= !key_release;  // Set on make, clear on break.
        end
    end

    // ==================================================
    // Most recent event and fresh press strobe
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            last_change <= '0;
        end else if (key_valid) begin
            last_change <= key_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            been_ready <= 1'b0;
        end else begin
            been_ready <= fresh_press;  // One cycle only.
        end
    end

endmodule

/* letter_checker.sv */
`timescale 1ns/1ps

module letter_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::game_state_t  state,
    input  logic                   been_ready,
    input  key_pkg::key_code_t     last_change,
    output logic                   correct,
    output logic                   wrong,
    output game_pkg::word_cnt_t    word_cnt,
    output game_pkg::mistake_cnt_t mistake_cnt
);

    // ==================================================
    // Target letter sequence
    // ==================================================
    localparam int SEQ_LEN = 6;
    localparam int IDX_W   = $clog2(SEQ_LEN);

    localparam key_pkg::key_code_t SEQ [SEQ_LEN] = '{
        key_pkg::KEY_A,
        key_pkg::KEY_S,
        key_pkg::KEY_D,
        key_pkg::KEY_F,
        key_pkg::KEY_J,
        key_pkg::KEY_K
    };

    logic [IDX_W-1:0]   seq_idx;
    key_pkg::key_code_t expected;
    logic               judge;
    logic               match;

    assign expected = SEQ[seq_idx];

    // Only presses while a game is running and unfinished are judged.
    assign judge = (state == game_pkg::WORD) && been_ready &&
                   (word_cnt < game_pkg::WORD_TARGET);
    assign match = (last_change == expected);

    // ==================================================
    // Judgement strobes
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            correct <= 1'b0;
            wrong   <= 1'b0;
        end else begin
            correct <= judge && match;
            wrong   <= judge && !match;
        end
    end

    // ==================================================
    // Sequence index and counts
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_idx     <= '0;
            word_cnt    <= '0;
            mistake_cnt <= '0;
        end else if (state == game_pkg::WAIT) begin
            seq_idx     <= '0;  // New game starts from the first letter.
            word_cnt    <= '0;
            mistake_cnt <= '0;
        end else if (judge) begin
            if (match) begin
                // Wrap so a longer target reuses the sequence.
                if (seq_idx == IDX_W'(SEQ_LEN - 1)) begin
                    seq_idx <= '0;
                end else begin
                    seq_idx <= seq_idx + 1'b1;
                end
                word_cnt <= word_cnt + 1'b1;
            end else if (mistake_cnt != '1) begin
                mistake_cnt <= mistake_cnt + 1'b1;  // Saturating.
            end
        end
    end

endmodule

/* penalty_timer.sv */
`timescale 1ns/1ps

module penalty_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wrong,
    output game_pkg::penalty_cnt_t wrong_cnt
);

    logic counting;

    assign counting = (wrong_cnt != '0);

    // ==================================================
    // Penalty countdown
    // ==================================================
    // Loads on the same edge the FSM enters WRONG, then runs down
    // once per cycle and rests at zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            wrong_cnt <= '0;
        end else if (wrong) begin
            wrong_cnt <= game_pkg::PENALTY_CYCLES;
        end else if (counting) begin
            wrong_cnt <= wrong_cnt - 1'b1;
        end
    end

endmodule

/* tb_typing_game.sv */
`timescale 1ns/1ps

module tb_typing_game;

    localparam int SETTLE_MIN = 2;   // Edges left after the strobe before a result shows.
    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   rst;
    logic                   key_valid;
    key_pkg::key_code_t     key_code;
    logic                   key_release;
    game_pkg::game_state_t  state;
    game_pkg::word_cnt_t    word_cnt;
    game_pkg::mistake_cnt_t mistake_cnt;
    game_pkg::penalty_cnt_t wrong_cnt;

    logic                   check;
    logic                   summary;
    int                     row;
    game_pkg::game_state_t  exp_state;
    game_pkg::word_cnt_t    exp_word;
    game_pkg::mistake_cnt_t exp_mistake;
    game_pkg::penalty_cnt_t exp_peak;
    int                     timeouts;
    int                     assert_fails;
    int                     error_count;

    // Stimulus table, one entry per key event.
    key_pkg::key_code_t     tbl_code[$];
    logic                   tbl_release[$];
    game_pkg::game_state_t  tbl_state[$];
    game_pkg::word_cnt_t    tbl_word[$];
    game_pkg::mistake_cnt_t tbl_mistake[$];

    typing_game_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .key_release (key_release),
        .state       (state),
        .word_cnt    (word_cnt),
        .mistake_cnt (mistake_cnt),
        .wrong_cnt   (wrong_cnt)
    );

    typing_game_monitor mon_i (
        .clk          (clk),
        .check        (check),
        .summary      (summary),
        .row          (row),
        .exp_state    (exp_state),
        .exp_word     (exp_word),
        .exp_mistake  (exp_mistake),
        .exp_peak     (exp_peak),
        .state        (state),
        .word_cnt     (word_cnt),
        .mistake_cnt  (mistake_cnt),
        .wrong_cnt    (wrong_cnt),
        .timeouts     (timeouts),
        .assert_fails (assert_fails),
        .error_count  (error_count)
    );

    bind game_fsm typing_game_checker fsm_check_i (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .wrong    (wrong),
        .word_cnt (word_cnt)
    );

    assign assert_fails = dut_i.fsm_i.fsm_check_i.assert_fails;

    always #20 clk = ~clk;

    task automatic add_row(input key_pkg::key_code_t code, input logic brk,
                           input game_pkg::game_state_t st, input int words,
                           input int mistakes);
        tbl_code.push_back(code);
        tbl_release.push_back(brk);
        tbl_state.push_back(st);
        tbl_word.push_back(game_pkg::word_cnt_t'(words));
        tbl_mistake.push_back(game_pkg::mistake_cnt_t'(mistakes));
    endtask

    // Called on a falling edge, leaves key_valid high for one cycle.
    task automatic send_key(input key_pkg::key_code_t code, input logic brk);
        key_valid   = 1'b1;
        key_code    = code;
        key_release = brk;
        @(negedge clk);
        key_valid   = 1'b0;
    endtask

    // Start delay and penalty are timed phases, so wait them out.
    task automatic wait_settled(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (cycles >= SETTLE_MIN && state != game_pkg::WAIT_TO_START &&
                state != game_pkg::WRONG) begin
                ok = 1'b1;
            end
        end
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    initial begin
        add_row(key_pkg::KEY_A, 1'b0, game_pkg::WAIT, 0, 0);       // Ignored before Enter.
        add_row(key_pkg::KEY_A, 1'b1, game_pkg::WAIT, 0, 0);
        add_row(key_pkg::KEY_ENTER, 1'b0, game_pkg::WORD, 0, 0);
        add_row(key_pkg::KEY_ENTER, 1'b1, game_pkg::WORD, 0, 0);
        add_row(key_pkg::KEY_A, 1'b0, game_pkg::WORD, 1, 0);
        add_row(key_pkg::KEY_A, 1'b0, game_pkg::WORD, 1, 0);       // Typematic repeat.
        add_row(key_pkg::KEY_A, 1'b1, game_pkg::WORD, 1, 0);
        add_row(key_pkg::KEY_S, 1'b0, game_pkg::WORD, 2, 0);
        add_row(key_pkg::KEY_S, 1'b1, game_pkg::WORD, 2, 0);
        add_row(key_pkg::KEY_J, 1'b0, game_pkg::WORD, 2, 1);       // D was due.
        add_row(key_pkg::KEY_J, 1'b1, game_pkg::WORD, 2, 1);
        add_row(key_pkg::KEY_D, 1'b0, game_pkg::WORD, 3, 1);
        add_row(key_pkg::KEY_D, 1'b1, game_pkg::WORD, 3, 1);
        add_row(key_pkg::KEY_F, 1'b0, game_pkg::WORD, 4, 1);
        add_row(key_pkg::KEY_F, 1'b1, game_pkg::WORD, 4, 1);
        add_row(key_pkg::KEY_J, 1'b0, game_pkg::WORD, 5, 1);
        add_row(key_pkg::KEY_J, 1'b1, game_pkg::WORD, 5, 1);
        add_row(key_pkg::KEY_K, 1'b0, game_pkg::FINISH, 6, 1);
        add_row(key_pkg::KEY_K, 1'b1, game_pkg::FINISH, 6, 1);
        add_row(key_pkg::KEY_ENTER, 1'b0, game_pkg::WAIT, 0, 0);
        add_row(key_pkg::KEY_ENTER, 1'b1, game_pkg::WAIT, 0, 0);
        // Second game.
        add_row(key_pkg::KEY_ENTER, 1'b0, game_pkg::WORD, 0, 0);
        add_row(key_pkg::KEY_ENTER, 1'b1, game_pkg::WORD, 0, 0);
        add_row(key_pkg::KEY_A, 1'b0, game_pkg::WORD, 1, 0);
        add_row(key_pkg::KEY_A, 1'b1, game_pkg::WORD, 1, 0);
        add_row(key_pkg::KEY_K, 1'b0, game_pkg::WORD, 1, 1);
        add_row(key_pkg::KEY_K, 1'b1, game_pkg::WORD, 1, 1);
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        logic ok;
        clk         = 1'b0;
        rst         = 1'b1;
        key_valid   = 1'b0;
        key_code    = '0;
        key_release = 1'b0;
        check       = 1'b0;
        summary     = 1'b0;
        row         = 0;
        exp_state   = game_pkg::WAIT;
        exp_word    = '0;
        exp_mistake = '0;
        exp_peak    = '0;
        timeouts    = 0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
        end
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < tbl_code.size() && timeouts == 0; i++) begin
            send_key(tbl_code[i], tbl_release[i]);
            wait_settled(ok);
            if (!ok) begin
                $display("Timeout: row %0d never settled, game stuck in state %0d", i, state);
                timeouts++;
            end else begin
                row         = i;
                exp_state   = tbl_state[i];
                exp_word    = tbl_word[i];
                // A new mistake loads the full penalty.
                exp_peak    = (tbl_mistake[i] > exp_mistake) ? game_pkg::PENALTY_CYCLES : '0;
                exp_mistake = tbl_mistake[i];
                check       = 1'b1;
                @(negedge clk);
                check       = 1'b0;
            end
        end
        summary = 1'b1;
        @(negedge clk);
        summary = 1'b0;
        if (error_count == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* typing_game_checker.sv */
`timescale 1ns/1ps

module typing_game_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::game_state_t state,
    input  logic                  wrong,
    input  game_pkg::word_cnt_t   word_cnt
);

    int assert_fails = 0;  // Read by the testbench at the end of the run.
    int start_cycles;

    // Cycles already spent in WAIT_TO_START before the current one.
    always_ff @(posedge clk) begin
        if (rst || state != game_pkg::WAIT_TO_START) begin
            start_cycles <= 0;
        end else begin
            start_cycles <= start_cycles + 1;
        end
    end

    // ==================================================
    // Game invariants
    // ==================================================
    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {game_pkg::WAIT, game_pkg::WAIT_TO_START, game_pkg::WORD,
                      game_pkg::WRONG, game_pkg::FINISH})
        else begin
            assert_fails++;
            $error("FSM state holds an illegal encoding");
        end

    word_cnt_bounded: assert property (@(posedge clk) disable iff (rst)
        word_cnt <= game_pkg::WORD_TARGET)
        else begin
            assert_fails++;
            $error("word_cnt went past the target count");
        end

    wrong_enters_penalty: assert property (@(posedge clk) disable iff (rst)
        (state == game_pkg::WORD) && wrong |=> state == game_pkg::WRONG)
        else begin
            assert_fails++;
            $error("Wrong strobe in WORD was not followed by WRONG");
        end

    start_delay_bounded: assert property (@(posedge clk) disable iff (rst)
        state == game_pkg::WAIT_TO_START |-> start_cycles <= int'(game_pkg::START_DELAY))
        else begin
            assert_fails++;
            $error("WAIT_TO_START lasted longer than the start delay");
        end

endmodule

/* typing_game_monitor.sv */
`timescale 1ns/1ps

module typing_game_monitor (
    input  logic                   clk,
    input  logic                   check,
    input  logic                   summary,
    input  int                     row,
    input  game_pkg::game_state_t  exp_state,
    input  game_pkg::word_cnt_t    exp_word,
    input  game_pkg::mistake_cnt_t exp_mistake,
    input  game_pkg::penalty_cnt_t exp_peak,
    input  game_pkg::game_state_t  state,
    input  game_pkg::word_cnt_t    word_cnt,
    input  game_pkg::mistake_cnt_t mistake_cnt,
    input  game_pkg::penalty_cnt_t wrong_cnt,
    input  int                     timeouts,
    input  int                     assert_fails,
    output int                     error_count
);

    int                     pass_count;
    game_pkg::penalty_cnt_t peak_cnt;

    function automatic string state_text(input game_pkg::game_state_t s);
        case (s)
            game_pkg::WAIT:          return "WAIT";
            game_pkg::WAIT_TO_START: return "WAIT_TO_START";
            game_pkg::WORD:          return "WORD";
            game_pkg::WRONG:         return "WRONG";
            game_pkg::FINISH:        return "FINISH";
            default:                 return "ILLEGAL";
        endcase
    endfunction

    initial begin
        error_count = 0;
        pass_count  = 0;
        peak_cnt    = '0;
    end

    // ==================================================
    // Row comparison and closing counts
    // ==================================================
    always @(posedge clk) begin
        if (wrong_cnt > peak_cnt) begin
            peak_cnt = wrong_cnt;  // Highest penalty count since the last row.
        end
        if (check) begin
            if (state == exp_state && word_cnt == exp_word && mistake_cnt == exp_mistake &&
                peak_cnt == exp_peak) begin
                pass_count++;
                $display("Row %0d ok: %s word_cnt %0d mistakes %0d penalty %0d",
                         row, state_text(state), word_cnt, mistake_cnt, peak_cnt);
            end else begin
                error_count++;
                $display("[ERROR] %0t: row %0d got %s/%0d/%0d/%0d, expected %s/%0d/%0d/%0d",
                         $time, row, state_text(state), word_cnt, mistake_cnt, peak_cnt,
                         state_text(exp_state), exp_word, exp_mistake, exp_peak);
            end
            peak_cnt = '0;
        end
        if (summary) begin  // Totals for the whole run.
            $display("Rows ok %0d, rows wrong %0d, timeouts %0d, assertion failures %0d",
                     pass_count, error_count, timeouts, assert_fails);
        end
    end

endmodule

/* typing_game_top.sv */
`timescale 1ns/1ps

module typing_game_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key_valid,
    input  key_pkg::key_code_t     key_code,
    input  logic                   key_release,
    output game_pkg::game_state_t  state,
    output game_pkg::word_cnt_t    word_cnt,
    output game_pkg::mistake_cnt_t mistake_cnt,
    output game_pkg::penalty_cnt_t wrong_cnt
);

    key_pkg::key_map_t    key_down;
    key_pkg::key_code_t   last_change;
    logic                 been_ready;
    logic                 wrong;

    key_state_tracker tracker_i (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .key_release (key_release),
        .key_down    (key_down),
        .last_change (last_change),
        .been_ready  (been_ready)
    );

    letter_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .been_ready  (been_ready),
        .last_change (last_change),
        .correct     (),
        .wrong       (wrong),
        .word_cnt    (word_cnt),
        .mistake_cnt (mistake_cnt)
    );

    penalty_timer timer_i (
        .clk       (clk),
        .rst       (rst),
        .wrong     (wrong),
        .wrong_cnt (wrong_cnt)
    );

    game_fsm fsm_i (
        .clk         (clk),
        .rst         (rst),
        .key_down    (key_down),
        .last_change (last_change),
        .been_ready  (been_ready),
        .wrong       (wrong),
        .word_cnt    (word_cnt),
        .wrong_cnt   (wrong_cnt),
        .state       (state),
        .stcnt       ()
    );

endmodule
